//--- design/mem_meta_pkg.sv
// ======================================================================
// Memory metadata preserver shared definitions
// Bus widths for the source and sink read channels and the state
// encoding of the burst memory responder
// ======================================================================
package mem_meta_pkg;

    // Byte address of a read request
    localparam int ADDR_W = 16;
    // One response data beat
    localparam int DATA_W = 32;
    // Burst length field, the burst has len+1 beats
    localparam int LEN_W = 4;

    // Source side metadata that the sink cannot return
    localparam int SRC_ID_W = 4;
    localparam int USER_W = 4;

    // Tag ID carried through the sink
    localparam int SINK_ID_W = 4;

    // Responder FSM states
    typedef enum logic [0:0] {
        RSP_IDLE  = 1'b0,
        RSP_BURST = 1'b1
    } rsp_state_t;

endpackage

//--- design/meta_tag_ram.sv
// ======================================================================
// Metadata tag RAM
// Hands out the lowest free entry as a tag, stores the request's ID and
// USER there, returns them one cycle after a read and frees on request
// ======================================================================
`timescale 1ns/1ps

module meta_tag_ram
    import mem_meta_pkg::*;
#(
    parameter int NUM_CREDITS = 8
)
(
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  alloc_en,
    input  logic [SRC_ID_W+USER_W-1:0]            alloc_data,
    output logic                                  not_full,
    output logic [$clog2(NUM_CREDITS)-1:0]        alloc_idx,
    input  logic                                  read_en,
    input  logic [$clog2(NUM_CREDITS)-1:0]        read_idx,
    output logic [SRC_ID_W+USER_W-1:0]            read_data,
    input  logic                                  free_en,
    input  logic [$clog2(NUM_CREDITS)-1:0]        free_idx
);

    localparam int TAG_W = $clog2(NUM_CREDITS);
    localparam int META_W = SRC_ID_W + USER_W;

    // One busy bit per entry, set on allocation and cleared on free
    logic [NUM_CREDITS-1:0] busy;
    logic [META_W-1:0]      meta_mem [NUM_CREDITS];

    // A tag is available as long as one busy bit is still clear
    assign not_full = ~&busy;

    // Priority search for the lowest free entry, scanning from the top so
    // the last hit wins
    always_comb
    begin
        alloc_idx = '0;
        for (int i = NUM_CREDITS - 1; i >= 0; i--)
        begin
            if (!busy[i])
                alloc_idx = TAG_W'(i);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            busy <= '0;
        end
        else
        begin
            // Alloc and free never name the same entry in one cycle
            if (alloc_en)
                busy[alloc_idx] <= 1'b1;
            if (free_en)
                busy[free_idx] <= 1'b0;
        end
    end

    // Storage and the registered read port
    always_ff @(posedge clk)
    begin
        if (alloc_en)
            meta_mem[alloc_idx] <= alloc_data;
        if (read_en)
            read_data <= meta_mem[read_idx];
    end

    // The caller must gate allocation with not_full
    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!reset_n)
        alloc_en |-> not_full);

    // A free must match an earlier allocation still in flight
    a_free_only_busy: assert property (@(posedge clk) disable iff (!reset_n)
        free_en |-> busy[free_idx]);

endmodule

//--- design/rsp_skid_stage.sv
// ======================================================================
// Response skid stage
// Registered valid/ready stage with one output entry and one skid entry
// ======================================================================
`timescale 1ns/1ps

module rsp_skid_stage
    import mem_meta_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        in_valid,
    input  logic [SINK_ID_W+DATA_W:0]   in_data,
    output logic                        in_ready,
    output logic                        out_valid,
    output logic [SINK_ID_W+DATA_W:0]   out_data,
    input  logic                        out_ready
);

    logic                       skid_valid;
    logic                       skid_valid_nxt;
    logic [SINK_ID_W+DATA_W:0]  skid_data;
    logic                       in_xfer;
    logic                       out_stall;

    assign in_xfer = in_valid && in_ready;
    assign out_stall = out_valid && !out_ready;

    // The skid entry fills when a beat arrives against a stalled output
    // and drains into the output register once the stall clears
    always_comb
    begin
        skid_valid_nxt = skid_valid;
        if (skid_valid && out_ready)
            skid_valid_nxt = 1'b0;
        else if (in_xfer && out_stall)
            skid_valid_nxt = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            skid_valid <= 1'b0;
            in_ready <= 1'b1;
            out_valid <= 1'b0;
        end
        else
        begin
            skid_valid <= skid_valid_nxt;
            // Accept new beats only while the skid entry will be empty
            in_ready <= !skid_valid_nxt;
            if (!out_stall)
                out_valid <= skid_valid || in_xfer;
        end
    end

    // Payload registers, the skid entry always has priority as it is older
    always_ff @(posedge clk)
    begin
        if (in_xfer && out_stall)
            skid_data <= in_data;
        if (!out_stall)
            out_data <= skid_valid ? skid_data : in_data;
    end

    // A stalled beat must stay put until it is taken
    a_hold_under_stall: assert property (@(posedge clk) disable iff (!reset_n)
        out_stall |=> (out_valid && $stable(out_data)));

endmodule

//--- design/meta_preserve.sv
// ======================================================================
// Read metadata preserver
// Swaps the source ID for a RAM tag on requests and restores ID and
// USER on every beat of the burst response, in order
// ======================================================================
`timescale 1ns/1ps

module meta_preserve
    import mem_meta_pkg::*;
#(
    parameter int NUM_CREDITS = 8
)
(
    input  logic                    clk,
    input  logic                    reset_n,
    // Source side
    input  logic                    ar_valid,
    output logic                    ar_ready,
    input  logic [SRC_ID_W-1:0]     ar_id,
    input  logic [USER_W-1:0]       ar_user,
    input  logic [ADDR_W-1:0]       ar_addr,
    input  logic [LEN_W-1:0]        ar_len,
    output logic                    r_valid,
    input  logic                    r_ready,
    output logic [SRC_ID_W-1:0]     r_id,
    output logic [USER_W-1:0]       r_user,
    output logic [DATA_W-1:0]       r_data,
    output logic                    r_last,
    // Sink side
    output logic                    s_ar_valid,
    input  logic                    s_ar_ready,
    output logic [SINK_ID_W-1:0]    s_ar_id,
    output logic [ADDR_W-1:0]       s_ar_addr,
    output logic [LEN_W-1:0]        s_ar_len,
    input  logic                    s_r_valid,
    output logic                    s_r_ready,
    input  logic [SINK_ID_W-1:0]    s_r_id,
    input  logic [DATA_W-1:0]       s_r_data,
    input  logic                    s_r_last
);

    localparam int TAG_W = $clog2(NUM_CREDITS);
    localparam int META_W = SRC_ID_W + USER_W;

    logic                       tag_not_full;
    logic [TAG_W-1:0]           alloc_idx;
    logic [TAG_W-1:0]           read_idx;
    logic [META_W-1:0]          read_data;
    logic                       s_r_xfer;
    logic                       r_xfer;
    logic                       is_sop;
    logic [TAG_W-1:0]           hdr_idx;
    logic                       free_en;
    logic                       rd_valid;
    logic [SINK_ID_W+DATA_W:0]  beat_out;
    logic [META_W-1:0]          mfifo_mem [2];
    logic                       mfifo_wr_ptr;
    logic                       mfifo_rd_ptr;
    logic [1:0]                 mfifo_cnt;
    logic                       meta_enq;
    logic                       meta_deq;
    logic [META_W-1:0]          meta_head;

    // ==================================================================
    // Request path
    // ==================================================================

    // Requests go through only while a tag is free, the tag replaces the ID
    assign s_ar_valid = ar_valid && tag_not_full;
    assign ar_ready = s_ar_ready && tag_not_full;
    assign s_ar_id = SINK_ID_W'(alloc_idx);
    assign s_ar_addr = ar_addr;
    assign s_ar_len = ar_len;

    // ==================================================================
    // Response path
    // ==================================================================

    assign s_r_xfer = s_r_valid && s_r_ready;
    assign r_xfer = r_valid && r_ready;

    // Only the first beat of a burst carries a usable tag lookup, the rest
    // reuse the held header index
    assign read_idx = is_sop ? TAG_W'(s_r_id) : hdr_idx;

    always_ff @(posedge clk)
    begin
        if (s_r_xfer && is_sop)
            hdr_idx <= TAG_W'(s_r_id);
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            is_sop <= 1'b1;
            free_en <= 1'b0;
            rd_valid <= 1'b0;
        end
        else
        begin
            // The beat after a last beat starts a new burst
            if (s_r_xfer)
                is_sop <= s_r_last;
            // Release the entry one cycle after the burst's final beat
            free_en <= s_r_xfer && s_r_last;
            // RAM result shows up one cycle after the lookup
            rd_valid <= s_r_xfer;
        end
    end

    meta_tag_ram #(
        .NUM_CREDITS (NUM_CREDITS)
    ) u_meta_tag_ram (
        .clk        (clk),
        .reset_n    (reset_n),
        .alloc_en   (ar_valid && ar_ready),
        .alloc_data ({ar_id, ar_user}),
        .not_full   (tag_not_full),
        .alloc_idx  (alloc_idx),
        .read_en    (s_r_xfer),
        .read_idx   (read_idx),
        .read_data  (read_data),
        .free_en    (free_en),
        .free_idx   (hdr_idx)
    );

    // Beat is delayed one cycle so it lines up with the RAM read
    rsp_skid_stage u_rsp_skid_stage (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (s_r_valid),
        .in_data   ({s_r_id, s_r_data, s_r_last}),
        .in_ready  (s_r_ready),
        .out_valid (r_valid),
        .out_data  (beat_out),
        .out_ready (r_ready)
    );

    // Two entry metadata FIFO with bypass. The skid stage holds at most two
    // beats, so at most two lookups can be waiting for the source
    assign meta_enq = rd_valid && !(mfifo_cnt == 2'd0 && r_xfer);
    assign meta_deq = r_xfer && (mfifo_cnt != 2'd0);
    assign meta_head = (mfifo_cnt != 2'd0) ? mfifo_mem[mfifo_rd_ptr] : read_data;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mfifo_wr_ptr <= 1'b0;
            mfifo_rd_ptr <= 1'b0;
            mfifo_cnt <= 2'd0;
        end
        else
        begin
            if (meta_enq)
                mfifo_wr_ptr <= !mfifo_wr_ptr;
            if (meta_deq)
                mfifo_rd_ptr <= !mfifo_rd_ptr;
            if (meta_enq && !meta_deq)
                mfifo_cnt <= mfifo_cnt + 2'd1;
            else if (meta_deq && !meta_enq)
                mfifo_cnt <= mfifo_cnt - 2'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (meta_enq)
            mfifo_mem[mfifo_wr_ptr] <= read_data;
    end

    // Restore the source metadata onto the beat, the tag bits are dropped
    assign {r_id, r_user} = meta_head;
    assign r_data = beat_out[DATA_W:1];
    assign r_last = beat_out[0];

    // Skid depth bounds the number of pending lookups
    a_mfifo_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        (meta_enq && !meta_deq) |-> (mfifo_cnt != 2'd2));

    // Every visible beat must already have its metadata
    a_meta_ready_with_beat: assert property (@(posedge clk) disable iff (!reset_n)
        r_valid |-> (mfifo_cnt != 2'd0 || rd_valid));

endmodule

//--- design/burst_mem_responder.sv
// ======================================================================
// Burst memory responder
// Sink model that queues read requests and returns each as a burst of
// computed data beats tagged with the request's ID
// ======================================================================
`timescale 1ns/1ps

module burst_mem_responder
    import mem_meta_pkg::*;
#(
    parameter int REQ_DEPTH = 4
)
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    s_ar_valid,
    output logic                    s_ar_ready,
    input  logic [SINK_ID_W-1:0]    s_ar_id,
    input  logic [ADDR_W-1:0]       s_ar_addr,
    input  logic [LEN_W-1:0]        s_ar_len,
    output logic                    s_r_valid,
    input  logic                    s_r_ready,
    output logic [SINK_ID_W-1:0]    s_r_id,
    output logic [DATA_W-1:0]       s_r_data,
    output logic                    s_r_last
);

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    logic [SINK_ID_W-1:0]   q_id   [REQ_DEPTH];
    logic [ADDR_W-1:0]      q_addr [REQ_DEPTH];
    logic [LEN_W-1:0]       q_len  [REQ_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       q_cnt;
    logic                   push;
    logic                   pop;
    logic                   beat_xfer;
    logic [LEN_W-1:0]       beat_cnt;
    rsp_state_t             state;

    // ==================================================================
    // Request queue
    // ==================================================================

    assign s_ar_ready = (q_cnt < CNT_W'(REQ_DEPTH));
    assign push = s_ar_valid && s_ar_ready;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            q_id[wr_ptr] <= s_ar_id;
            q_addr[wr_ptr] <= s_ar_addr;
            q_len[wr_ptr] <= s_ar_len;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                q_cnt <= q_cnt + 1'b1;
            else if (pop && !push)
                q_cnt <= q_cnt - 1'b1;
        end
    end

    // ==================================================================
    // Burst FSM
    // ==================================================================

    assign s_r_valid = (state == RSP_BURST);
    assign beat_xfer = s_r_valid && s_r_ready;
    assign s_r_last = (beat_cnt == q_len[rd_ptr]);
    // Head request retires with its final beat
    assign pop = beat_xfer && s_r_last;

    assign s_r_id = q_id[rd_ptr];
    // Beat k reads from the head address plus 4 times k
    assign s_r_data = DATA_W'(q_addr[rd_ptr]) + (DATA_W'(beat_cnt) << 2);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= RSP_IDLE;
            beat_cnt <= '0;
        end
        else
        begin
            case (state)
                RSP_IDLE:
                begin
                    beat_cnt <= '0;
                    if (q_cnt != '0)
                        state <= RSP_BURST;
                end
                RSP_BURST:
                begin
                    if (pop)
                    begin
                        // Go straight on when another request is queued
                        beat_cnt <= '0;
                        state <= (q_cnt > CNT_W'(1)) ? RSP_BURST : RSP_IDLE;
                    end
                    else if (beat_xfer)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                default:
                begin
                    state <= RSP_IDLE;
                end
            endcase
        end
    end

endmodule

//--- design/mem_meta_top.sv
// ======================================================================
// Memory metadata preserver subsystem
// Preserver in front of a burst memory responder
// ======================================================================
`timescale 1ns/1ps

module mem_meta_top
    import mem_meta_pkg::*;
#(
    parameter int NUM_CREDITS = 8,
    parameter int REQ_DEPTH = 4
)
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    input  logic [SRC_ID_W-1:0]     ar_id,
    input  logic [USER_W-1:0]       ar_user,
    input  logic [ADDR_W-1:0]       ar_addr,
    input  logic [LEN_W-1:0]        ar_len,
    output logic                    r_valid,
    input  logic                    r_ready,
    output logic [SRC_ID_W-1:0]     r_id,
    output logic [USER_W-1:0]       r_user,
    output logic [DATA_W-1:0]       r_data,
    output logic                    r_last
);

    // Sink side channels between the preserver and the responder
    logic                   s_ar_valid;
    logic                   s_ar_ready;
    logic [SINK_ID_W-1:0]   s_ar_id;
    logic [ADDR_W-1:0]      s_ar_addr;
    logic [LEN_W-1:0]       s_ar_len;
    logic                   s_r_valid;
    logic                   s_r_ready;
    logic [SINK_ID_W-1:0]   s_r_id;
    logic [DATA_W-1:0]      s_r_data;
    logic                   s_r_last;

    meta_preserve #(
        .NUM_CREDITS (NUM_CREDITS)
    ) u_meta_preserve (
        .clk        (clk),
        .reset_n    (reset_n),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar_id      (ar_id),
        .ar_user    (ar_user),
        .ar_addr    (ar_addr),
        .ar_len     (ar_len),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r_id       (r_id),
        .r_user     (r_user),
        .r_data     (r_data),
        .r_last     (r_last),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .s_ar_id    (s_ar_id),
        .s_ar_addr  (s_ar_addr),
        .s_ar_len   (s_ar_len),
        .s_r_valid  (s_r_valid),
        .s_r_ready  (s_r_ready),
        .s_r_id     (s_r_id),
        .s_r_data   (s_r_data),
        .s_r_last   (s_r_last)
    );

    burst_mem_responder #(
        .REQ_DEPTH (REQ_DEPTH)
    ) u_burst_mem_responder (
        .clk        (clk),
        .reset_n    (reset_n),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .s_ar_id    (s_ar_id),
        .s_ar_addr  (s_ar_addr),
        .s_ar_len   (s_ar_len),
        .s_r_valid  (s_r_valid),
        .s_r_ready  (s_r_ready),
        .s_r_id     (s_r_id),
        .s_r_data   (s_r_data),
        .s_r_last   (s_r_last)
    );

endmodule

//--- sim/mem_meta_tb.sv
// ======================================================================
// Memory metadata preserver testbench
// Random read requests from a fixed seed, a queue model of the expected
// response beats, random and held back-pressure on the response channel
// ======================================================================
`timescale 1ns/1ps

module mem_meta_tb
    import mem_meta_pkg::*;
();

    localparam int NUM_CREDITS = 8;
    localparam int REQ_DEPTH = 4;
    // Expected beat layout is {id, user, data, last}
    localparam int BEAT_W = SRC_ID_W + USER_W + DATA_W + 1;

    logic                   clk;
    logic                   reset_n;
    logic                   ar_valid;
    logic                   ar_ready;
    logic [SRC_ID_W-1:0]    ar_id;
    logic [USER_W-1:0]      ar_user;
    logic [ADDR_W-1:0]      ar_addr;
    logic [LEN_W-1:0]       ar_len;
    logic                   r_valid;
    logic                   r_ready;
    logic [SRC_ID_W-1:0]    r_id;
    logic [USER_W-1:0]      r_user;
    logic [DATA_W-1:0]      r_data;
    logic                   r_last;

    logic [BEAT_W-1:0]      exp_q [$];
    logic [BEAT_W-1:0]      exp_beat;
    logic [BEAT_W-1:0]      act_beat;
    int                     mismatch_cnt;
    int                     timeout_cnt;
    int                     other_cnt;
    int                     outstanding;
    int                     max_outstanding;
    bit                     req_seen;
    // 0 always ready, 1 random ready, 2 held low
    int                     r_mode;
    string                  test_name;
    int                     seed;
    bit                     acc;
    bit                     stalled;
    int                     n;

    mem_meta_top #(
        .NUM_CREDITS (NUM_CREDITS),
        .REQ_DEPTH   (REQ_DEPTH)
    ) u_mem_meta_top (
        .clk      (clk),
        .reset_n  (reset_n),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_id    (ar_id),
        .ar_user  (ar_user),
        .ar_addr  (ar_addr),
        .ar_len   (ar_len),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_id     (r_id),
        .r_user   (r_user),
        .r_data   (r_data),
        .r_last   (r_last)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Response back-pressure follows the current mode and changes on the falling edge
    initial
    begin
        r_ready = 1'b0;
        forever
        begin
            @(negedge clk);
            case (r_mode)
                0: r_ready = 1'b1;
                1: r_ready = ($urandom_range(99) >= 40);
                default: r_ready = 1'b0;
            endcase
        end
    end

    // ==================================================================
    // Reference model and response checker
    // ==================================================================

    // Beat k of a burst at address A carries A plus 4 times k
    task automatic push_expected(input logic [SRC_ID_W-1:0] id, input logic [USER_W-1:0] user,
                                 input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len);
        logic [DATA_W-1:0] data;
        logic              last;
        for (int k = 0; k <= int'(len); k++)
        begin
            data = DATA_W'(addr) + DATA_W'(4 * k);
            last = (k == int'(len));
            exp_q.push_back({id, user, data, last});
        end
    endtask

    task automatic check_beat();
        string exp_str;
        string act_str;
        act_beat = {r_id, r_user, r_data, r_last};
        if (exp_q.size() == 0)
        begin
            $display("%s: response beat arrived with no beat expected", test_name);
            other_cnt++;
        end
        else
        begin
            exp_beat = exp_q.pop_front();
            if (act_beat !== exp_beat)
            begin
                exp_str = $sformatf("id=%h user=%h data=%h last=%b",
                                    exp_beat[BEAT_W-1 -: SRC_ID_W],
                                    exp_beat[DATA_W+USER_W -: USER_W],
                                    exp_beat[DATA_W:1], exp_beat[0]);
                act_str = $sformatf("id=%h user=%h data=%h last=%b",
                                    r_id, r_user, r_data, r_last);
                $display("mismatch %s: expected %s, actual %s", test_name, exp_str, act_str);
                mismatch_cnt++;
            end
        end
        if (r_last)
            outstanding--;
    endtask

    // Handshakes are sampled at the rising edge where every transfer happens
    always @(posedge clk)
    begin
        if (reset_n)
        begin
            if (ar_valid && ar_ready)
            begin
                req_seen = 1'b1;
                push_expected(ar_id, ar_user, ar_addr, ar_len);
                outstanding++;
            end
            if (r_valid && !req_seen)
            begin
                $display("%s: r_valid went high before any request was accepted", test_name);
                other_cnt++;
            end
            if (r_valid && r_ready)
                check_beat();
            if (outstanding > max_outstanding)
                max_outstanding = outstanding;
            if (outstanding > NUM_CREDITS)
            begin
                $display("%s: %0d requests outstanding, more than the %0d credits",
                         test_name, outstanding, NUM_CREDITS);
                other_cnt++;
            end
        end
    end

    // ==================================================================
    // Stimulus tasks
    // ==================================================================

    task automatic report_timeout(input string what);
        rsp_state_t st;
        st = u_mem_meta_top.u_burst_mem_responder.state;
        $display("%s: timed out waiting for %s, responder state %s, %0d beats still expected",
                 test_name, what, st.name(), exp_q.size());
        timeout_cnt++;
    endtask

    // Called on a falling edge so the request holds steady until it is taken
    task automatic offer_random_request(input int max_len);
        ar_valid = 1'b1;
        ar_id = SRC_ID_W'($urandom);
        ar_user = USER_W'($urandom);
        ar_addr = ADDR_W'($urandom);
        ar_len = LEN_W'($urandom_range(max_len));
    endtask

    // Returns on the falling edge after the transfer or after the timeout
    task automatic wait_accept(input int max_wait, output bit accepted);
        int waited;
        waited = 0;
        accepted = 1'b0;
        while (!accepted && waited < max_wait)
        begin
            @(posedge clk);
            if (ar_ready)
                accepted = 1'b1;
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic send_random_requests(input int count, input int max_len);
        bit ok;
        for (int i = 0; i < count; i++)
        begin
            offer_random_request(max_len);
            wait_accept(200, ok);
            if (!ok)
                report_timeout("ar_ready");
            ar_valid = 1'b0;
            // Short random gap between requests
            repeat ($urandom_range(2)) @(negedge clk);
        end
    endtask

    task automatic wait_drain(input int max_wait);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < max_wait)
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
            report_timeout("the response beats to drain");
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial
    begin
        seed = 45;
        void'($urandom(seed));
        reset_n = 1'b0;
        ar_valid = 1'b0;
        ar_id = '0;
        ar_user = '0;
        ar_addr = '0;
        ar_len = '0;
        r_mode = 0;
        mismatch_cnt = 0;
        timeout_cnt = 0;
        other_cnt = 0;
        outstanding = 0;
        max_outstanding = 0;
        req_seen = 1'b0;
        test_name = "reset";
        repeat (5) @(negedge clk);
        reset_n = 1'b1;

        // No response may appear while nothing was asked for
        test_name = "idle_after_reset";
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            if (r_valid)
            begin
                $display("%s: r_valid high with no request issued", test_name);
                other_cnt++;
            end
        end

        test_name = "single_beat";
        send_random_requests(20, 0);
        wait_drain(500);

        test_name = "random_burst";
        send_random_requests(20, 15);
        wait_drain(2000);

        test_name = "random_backpressure";
        r_mode = 1;
        send_random_requests(30, 15);
        wait_drain(4000);
        r_mode = 0;

        // Fill the pipeline against a stalled source until ar_ready drops
        test_name = "credit_limit";
        r_mode = 2;
        @(negedge clk);
        stalled = 1'b0;
        n = 0;
        while (!stalled && n < 24)
        begin
            offer_random_request(3);
            wait_accept(40, acc);
            if (acc)
            begin
                ar_valid = 1'b0;
                n++;
            end
            else
            begin
                stalled = 1'b1;
            end
        end
        if (!stalled)
        begin
            $display("%s: ar_ready never went low while r_ready was held low", test_name);
            other_cnt++;
        end
        $display("%s: %0d requests accepted, peak outstanding %0d", test_name, n, max_outstanding);
        r_mode = 0;
        // The request still held on the bus goes through once the stall clears
        if (stalled)
        begin
            wait_accept(200, acc);
            if (!acc)
                report_timeout("ar_ready after releasing r_ready");
            ar_valid = 1'b0;
        end
        wait_drain(2000);

        test_name = "final";
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0 || outstanding != 0)
        begin
            $display("%s: model queue holds %0d beats and %0d requests remain open",
                     test_name, exp_q.size(), outstanding);
            other_cnt++;
        end

        $display("error counts: mismatch %0d, timeout %0d, other %0d",
                 mismatch_cnt, timeout_cnt, other_cnt);
        if (mismatch_cnt + timeout_cnt + other_cnt == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- build.f
design/mem_meta_pkg.sv
design/meta_tag_ram.sv
design/rsp_skid_stage.sv
design/meta_preserve.sv
design/burst_mem_responder.sv
design/mem_meta_top.sv
sim/mem_meta_tb.sv
